/* Makefile */
VERILATOR   ?= verilator
BUILD_FLAGS ?= --binary --timing --assert
LINT_FLAGS  ?= --lint-only -Wall --timing
TOP         ?= tb_video_buffer
FILELIST    ?= files.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* block_reader.sv */
`include "video_config.svh"

module block_reader (
	input  logic                  clk,
	input  logic                  nrst,

	// Buffer handshake
	input  logic                  fresh,
	output logic                  take,

	// RAM read port
	output logic [`VB_ADDR_W-1:0] rd_addr,
	input  pixel_pkg::pixel_t     rd_pixel,

	// Outgoing pixel stream
	output pixel_pkg::pixel_out_t pixel_out
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_DRAIN
	} state_t;

	localparam logic [`VB_ADDR_W-1:0] LAST_ADDR = `VB_ADDR_W'(`VB_BLOCK_WORDS - 1);

	state_t state;

	// Output controls delayed to match the RAM read latency
	logic                  out_valid_q;
	logic                  out_last_q;
	logic [`VB_ADDR_W-1:0] out_index_q;

	// Take the block as soon as one is ready
	assign take = (state == ST_IDLE) && fresh;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state   <= ST_IDLE;
			rd_addr <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					rd_addr <= '0;
					if (take) begin
						state <= ST_READ;
					end
				end
				ST_READ: begin
					rd_addr <= rd_addr + 1'b1;
					if (rd_addr == LAST_ADDR) begin
						state <= ST_DRAIN;
					end
				end
				// Last word leaves the RAM in this cycle
				ST_DRAIN: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			out_valid_q <= 1'b0;
			out_last_q  <= 1'b0;
		end else begin
			out_valid_q <= (state == ST_READ);
			out_last_q  <= (state == ST_READ) && (rd_addr == LAST_ADDR);
		end
	end

	always_ff @(posedge clk) begin
		out_index_q <= rd_addr;
	end

	// Pixel data comes straight from the selected bank
	always_comb begin
		pixel_out.valid = out_valid_q;
		pixel_out.last  = out_last_q;
		pixel_out.index = out_index_q;
		pixel_out.pixel = rd_pixel;
	end

endmodule

/* buffer_pkg.sv */
`include "video_config.svh"

package buffer_pkg;

	localparam int BANK_W = $clog2(`VB_BANKS);

	// Index of one RAM bank
	typedef logic [BANK_W-1:0] bank_t;

	// Current owner of each role, the three fields never share a bank
	typedef struct packed {
		bank_t write_bank;
		bank_t read_bank;
		bank_t free_bank;
	} bank_roles_t;

	// Roles right after reset
	localparam bank_roles_t ROLES_RESET = '{
		write_bank: bank_t'(0),
		read_bank:  bank_t'(1),
		free_bank:  bank_t'(2)
	};

endpackage

/* dual_port_ram.sv */
`include "video_config.svh"

module dual_port_ram (
	input  logic                  clk,
	input  logic                  wr_en,
	input  logic [`VB_ADDR_W-1:0] wr_addr,
	input  pixel_pkg::pixel_t     wr_data,
	input  logic [`VB_ADDR_W-1:0] rd_addr,
	output pixel_pkg::pixel_t     rd_data
);

	import pixel_pkg::*;

	// Storage for one block
	pixel_t mem [`VB_BLOCK_WORDS];

	// Write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read port, data one cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* files.f */
+incdir+.
pixel_pkg.sv
buffer_pkg.sv
dual_port_ram.sv
triple_buffer.sv
block_reader.sv
video_buffer_top.sv
tb_video_buffer_assert.sv
tb_video_buffer.sv

/* pixel_pkg.sv */
`include "video_config.svh"

package pixel_pkg;

	// One RGB pixel, 8 bits per colour
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	// Input stream, one pixel per cycle with valid high
	typedef struct packed {
		logic   valid;
		pixel_t pixel;
	} pixel_in_t;

	// Output stream, last marks the final word of a block
	typedef struct packed {
		logic                  valid;
		logic                  last;
		logic [`VB_ADDR_W-1:0] index;
		pixel_t                pixel;
	} pixel_out_t;

endpackage

/* tb_video_buffer.sv */
`include "video_config.svh"

module tb_video_buffer;

	timeunit 1ns;
	timeprecision 100ps;

	import pixel_pkg::*;

	localparam int LAST_WORD = `VB_BLOCK_WORDS - 1;
	// Worst case input length with up to 81 blocks in test 5
	localparam int TOTAL_PIXELS = (1 + 6 + 4 + 81) * `VB_BLOCK_WORDS;
	localparam int CYCLE_LIMIT = 4 * TOTAL_PIXELS + 1000;

	logic       clk;
	logic       nrst;
	pixel_in_t  pixel_in;
	pixel_out_t pixel_out;

	int          cyc = 0;
	logic [31:0] lfsr = 32'h5761_877e;
	int          next_blk = 0;
	int          errors = 0;

	// Completed input blocks and the cycles they completed in
	int comp_blk[$];
	int comp_cyc[$];

	// Output burst tracking
	bit in_burst = 1'b0;
	int burst_blk;
	int burst_pos;
	int bursts = 0;
	int last_out_blk = -1;
	bit same_cycle_seen = 1'b0;
	int coincide_bursts = 0;

	video_buffer_top video_buffer_top_i (
		.clk       (clk),
		.nrst      (nrst),
		.pixel_in  (pixel_in),
		.pixel_out (pixel_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles at %0t", cyc, $time);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	end

	// Block number in the upper bits and word index in the lower bits
	function automatic pixel_t make_pixel(input int blk, input int idx);
		logic [31:0] b;
		logic [31:0] i;
		b = blk;
		i = idx;
		return pixel_t'({b[23-`VB_ADDR_W:0], i[`VB_ADDR_W-1:0]});
	endfunction

	// Fibonacci LFSR with one step per returned bit
	function automatic logic [7:0] rand_bits(input int n);
		logic       fb;
		logic [7:0] val;
		val = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			val = {val[6:0], lfsr[31]};
			lfsr = {lfsr[30:0], fb};
		end
		return val;
	endfunction

	task automatic fail_now(input string msg);
		errors++;
		$display("%s (time %0t)", msg, $time);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic compare_pixel(input pixel_t got, input pixel_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic compare_index(input logic [`VB_ADDR_W-1:0] got,
		input logic [`VB_ADDR_W-1:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// Expected block is the newest one completed by the take
	task automatic check_output();
		int exp_blk;
		int take_cyc;
		logic [`VB_ADDR_W-1:0] exp_idx;
		exp_blk = -1;
		take_cyc = cyc - 2;
		if (pixel_out.valid) begin
			if (!in_burst) begin
				for (int i = comp_cyc.size() - 1; i >= 0; i--) begin
					if (exp_blk < 0 && comp_cyc[i] <= take_cyc) begin
						exp_blk = comp_blk[i];
						if (comp_cyc[i] == take_cyc && !same_cycle_seen) begin
							same_cycle_seen = 1'b1;
							coincide_bursts = bursts + 1;
						end
					end
				end
				if (exp_blk < 0) begin
					fail_now("Output burst started with no completed block");
				end
				if (exp_blk <= last_out_blk) begin
					fail_now("A block was output twice or out of order");
				end
				in_burst = 1'b1;
				burst_blk = exp_blk;
				burst_pos = 0;
			end
			exp_idx = burst_pos[`VB_ADDR_W-1:0];
			compare_index(pixel_out.index, exp_idx, "word index");
			compare_pixel(pixel_out.pixel, make_pixel(burst_blk, burst_pos), "pixel data");
			if (pixel_out.last) begin
				compare_index(pixel_out.index, `VB_ADDR_W'(LAST_WORD), "index at last");
				in_burst = 1'b0;
				bursts++;
				last_out_blk = burst_blk;
			end else if (burst_pos == LAST_WORD) begin
				fail_now("Last flag missing on the final word of a burst");
			end
			burst_pos++;
		end else if (in_burst) begin
			fail_now("Output valid dropped in the middle of a burst");
		end
	endtask

	// Sample in mid cycle where everything is stable
	always @(negedge clk) begin
		if (nrst) begin
			if (pixel_in.valid && pixel_in.pixel[`VB_ADDR_W-1:0] == LAST_WORD) begin
				comp_blk.push_back(int'(pixel_in.pixel[23:`VB_ADDR_W]));
				comp_cyc.push_back(cyc);
			end
			check_output();
		end
	end

	task automatic drive_pixel(input int blk, input int idx);
		@(posedge clk);
		pixel_in <= '{valid: 1'b1, pixel: make_pixel(blk, idx)};
	endtask

	task automatic drive_idle(input int n);
		repeat (n) begin
			@(posedge clk);
			pixel_in.valid <= 1'b0;
		end
	endtask

	task automatic send_block(input bit gaps);
		logic [7:0] r;
		for (int w = 0; w < `VB_BLOCK_WORDS; w++) begin
			if (gaps) begin
				r = rand_bits(3);
				if (r == 0) begin
					r = rand_bits(2);
					drive_idle(int'(r) + 1);
				end
			end
			drive_pixel(next_blk, w);
		end
		next_blk++;
	endtask

	task automatic wait_quiet();
		repeat (300) @(posedge clk);
		while (in_burst) @(posedge clk);
	endtask

	task automatic test_idle();
		drive_idle(300);
		if (bursts != 0) begin
			fail_now("Output burst appeared without any input");
		end
	endtask

	task automatic test_single_block();
		send_block(1'b0);
		drive_idle(1);
		wait_quiet();
		if (bursts != 1) begin
			fail_now("Single block was not output exactly once");
		end
	endtask

	task automatic test_back_to_back();
		int start;
		start = bursts;
		for (int b = 0; b < 6; b++) begin
			send_block(1'b0);
		end
		drive_idle(1);
		wait_quiet();
		if (bursts <= start || last_out_blk != next_blk - 1) begin
			fail_now("Back to back blocks did not end with the newest block output");
		end
	endtask

	task automatic test_random_gaps();
		int start;
		start = bursts;
		for (int b = 0; b < 4; b++) begin
			send_block(1'b1);
		end
		drive_idle(1);
		wait_quiet();
		if (bursts <= start || last_out_blk != next_blk - 1) begin
			fail_now("Gapped input did not end with the newest block output");
		end
	endtask

	// Reader falls 2 cycles behind per block and after enough blocks
	// take and completion meet in the same cycle
	task automatic test_same_cycle();
		bit stop;
		stop = 1'b0;
		same_cycle_seen = 1'b0;
		send_block(1'b0);
		drive_idle(1);
		for (int b = 0; b < 80 && !stop; b++) begin
			for (int w = 0; w < `VB_BLOCK_WORDS && !stop; w++) begin
				drive_pixel(next_blk, w);
				stop = same_cycle_seen;
			end
			next_blk++;
		end
		drive_idle(1);
		if (!same_cycle_seen) begin
			fail_now("Take never met a block completion in the same cycle");
		end
		wait_quiet();
		if (bursts != coincide_bursts) begin
			fail_now("Extra burst after the same cycle take without a new block");
		end
	endtask

	initial begin
		nrst = 1'b0;
		pixel_in = '0;
		repeat (10) @(posedge clk);
		nrst <= 1'b1;
		test_idle();
		test_single_block();
		test_back_to_back();
		test_random_gaps();
		test_same_cycle();
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* tb_video_buffer_assert.sv */
`include "video_config.svh"

module tb_video_buffer_assert #(
	parameter bit ROLES_CHECK = 1'b0
) (
	input logic                    clk,
	input logic                    nrst,
	input buffer_pkg::bank_roles_t roles,
	input logic                    take,
	input logic                    fresh,
	input logic                    out_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	import buffer_pkg::*;

	// A take consumes the fresh block, so fresh is low in the next cycle
	take_consumes_fresh: assert property (@(posedge clk) disable iff (!nrst)
		take |-> fresh ##1 !fresh)
		else $error("take without a fresh block or fresh not cleared after take");

	if (ROLES_CHECK) begin : g_roles
		banks_distinct: assert property (@(posedge clk) disable iff (!nrst)
			(roles.write_bank != roles.read_bank) &&
			(roles.write_bank != roles.free_bank) &&
			(roles.read_bank != roles.free_bank))
			else $error("two bank roles share one bank");

		banks_in_range: assert property (@(posedge clk) disable iff (!nrst)
			(roles.write_bank < bank_t'(`VB_BANKS)) &&
			(roles.read_bank < bank_t'(`VB_BANKS)) &&
			(roles.free_bank < bank_t'(`VB_BANKS)))
			else $error("bank index out of range");
	end else begin : g_stream
		// Length of the current run of valid output cycles
		int run_len;

		always_ff @(posedge clk or negedge nrst) begin
			if (!nrst) begin
				run_len <= 0;
			end else if (out_valid) begin
				run_len <= run_len + 1;
			end else begin
				run_len <= 0;
			end
		end

		// Burst starts two cycles after take
		take_starts_burst: assert property (@(posedge clk) disable iff (!nrst)
			take |-> ##2 out_valid)
			else $error("no output burst after take");

		burst_length: assert property (@(posedge clk) disable iff (!nrst)
			$fell(out_valid) |-> (run_len == `VB_BLOCK_WORDS))
			else $error("output burst length differs from one block");
	end

endmodule

bind triple_buffer tb_video_buffer_assert #(
	.ROLES_CHECK (1'b1)
) roles_assert_i (
	.clk       (clk),
	.nrst      (nrst),
	.roles     (roles),
	.take      (take),
	.fresh     (fresh),
	.out_valid (1'b0)
);

bind block_reader tb_video_buffer_assert #(
	.ROLES_CHECK (1'b0)
) stream_assert_i (
	.clk       (clk),
	.nrst      (nrst),
	.roles     (buffer_pkg::ROLES_RESET),
	.take      (take),
	.fresh     (fresh),
	.out_valid (pixel_out.valid)
);

/* triple_buffer.sv */
`include "video_config.svh"

module triple_buffer (
	input  logic                  clk,
	input  logic                  nrst,

	// Incoming pixel stream
	input  pixel_pkg::pixel_in_t  pixel_in,

	// Reader side
	input  logic                  take,
	input  logic [`VB_ADDR_W-1:0] rd_addr,
	output pixel_pkg::pixel_t     rd_pixel,
	output logic                  fresh
);

	import pixel_pkg::*;
	import buffer_pkg::*;

	// Word counter inside the block being written
	logic [`VB_ADDR_W-1:0] wr_cnt;

	// Block is complete on its last valid pixel
	logic blk_done;

	// Write stage, data, address and bank move together
	logic                  wr_en_q;
	logic [`VB_ADDR_W-1:0] wr_addr_q;
	pixel_t                wr_data_q;
	bank_t                 wr_bank_q;

	// Bank roles and their next value
	bank_roles_t roles;
	bank_roles_t roles_next;
	logic        fresh_next;

	// Per bank RAM signals
	logic [`VB_BANKS-1:0] bank_wr_en;
	pixel_t               bank_rd_data [`VB_BANKS];

	assign blk_done = pixel_in.valid && (wr_cnt == `VB_ADDR_W'(`VB_BLOCK_WORDS - 1));

	// Write address counter, wraps to 0 at the end of a block
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			wr_cnt <= '0;
		end else if (pixel_in.valid) begin
			wr_cnt <= wr_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			wr_en_q <= 1'b0;
		end else begin
			wr_en_q <= pixel_in.valid;
		end
	end

	// The bank is latched with the pixel, so the last word of a block
	// still lands in its bank after the roles have rotated
	always_ff @(posedge clk) begin
		wr_addr_q <= wr_cnt;
		wr_data_q <= pixel_in.pixel;
		wr_bank_q <= roles.write_bank;
	end

	// One RAM per bank
	for (genvar b = 0; b < `VB_BANKS; b++) begin : g_bank
		assign bank_wr_en[b] = wr_en_q && (wr_bank_q == bank_t'(b));

		dual_port_ram bank_ram_i (
			.clk     (clk),
			.wr_en   (bank_wr_en[b]),
			.wr_addr (wr_addr_q),
			.wr_data (wr_data_q),
			.rd_addr (rd_addr),
			.rd_data (bank_rd_data[b])
		);
	end

	// Read data from the bank the reader owns
	always_comb begin
		rd_pixel = bank_rd_data[0];
		for (int b = 1; b < `VB_BANKS; b++) begin
			if (roles.read_bank == bank_t'(b)) begin
				rd_pixel = bank_rd_data[b];
			end
		end
	end

	// Role rotation
	always_comb begin
		roles_next = roles;
		fresh_next = fresh;
		if (blk_done && take) begin
			// Free bank is older than the block just finished, so skip it
			roles_next.read_bank  = roles.write_bank;
			roles_next.write_bank = roles.read_bank;
			fresh_next            = 1'b0;
		end else if (take) begin
			roles_next.read_bank = roles.free_bank;
			roles_next.free_bank = roles.read_bank;
			fresh_next           = 1'b0;
		end else if (blk_done) begin
			// An unread block in the free bank gets overwritten later
			roles_next.write_bank = roles.free_bank;
			roles_next.free_bank  = roles.write_bank;
			fresh_next            = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			roles <= ROLES_RESET;
			fresh <= 1'b0;
		end else begin
			roles <= roles_next;
			fresh <= fresh_next;
		end
	end

endmodule

/* video_buffer_top.sv */
`include "video_config.svh"

module video_buffer_top (
	input  logic                  clk,
	input  logic                  nrst,
	input  pixel_pkg::pixel_in_t  pixel_in,
	output pixel_pkg::pixel_out_t pixel_out
);

	import pixel_pkg::*;

	// Between buffer and reader
	logic                  fresh;
	logic                  take;
	logic [`VB_ADDR_W-1:0] rd_addr;
	pixel_t                rd_pixel;

	triple_buffer triple_buffer_i (
		.clk      (clk),
		.nrst     (nrst),
		.pixel_in (pixel_in),
		.take     (take),
		.rd_addr  (rd_addr),
		.rd_pixel (rd_pixel),
		.fresh    (fresh)
	);

	block_reader block_reader_i (
		.clk       (clk),
		.nrst      (nrst),
		.fresh     (fresh),
		.take      (take),
		.rd_addr   (rd_addr),
		.rd_pixel  (rd_pixel),
		.pixel_out (pixel_out)
	);

endmodule

/* video_config.svh */
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// Pixels in one block, the size of one RAM bank
`define VB_BLOCK_WORDS 128

// Word address width inside a bank
`define VB_ADDR_W 7

// Banks rotating between write, read and free
`define VB_BANKS 3

`endif
